/* verilog.f */
+incdir+common
+incdir+test
common/isa_pkg.sv
common/core_pkg.sv
common/operand_if.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/branch_unit.sv
core/exec_control.sv
core/core_top.sv
test/tb_core.sv

/* run.sh */
#!/usr/bin/env bash
# compile the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_core -o tb_core

sim_out=$(./obj_dir/tb_core)
echo "$sim_out"

if grep -q "TESTBENCH PASSED" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* test/tb_cases.svh */
/*
 * Stimulus table and program builder for the core testbench.
 * Included inside tb_core after the memory array is declared.
 * Each row becomes a short program at the reset pc that ends in an
 * output store and a halt store.
 */
`ifndef TB_CASES_SVH
`define TB_CASES_SVH

typedef enum logic [2:0] {K_OP, K_IMM, K_LUI, K_BR, K_MEM, K_X0, K_BAD} kind_e;

typedef struct packed {
    kind_e       kind;
    logic [2:0]  fn;
    logic        alt;
    word_t       a;
    word_t       b;
    logic [19:0] imm;
    word_t       exp;
} row_t;

row_t  rows[$];
// byte address of the next free program slot
addr_t prog_pc;

function automatic void add_row(input kind_e k, input logic [2:0] fn, input logic alt,
                                input word_t a, input word_t b, input logic [19:0] imm,
                                input word_t exp);
    rows.push_back('{k, fn, alt, a, b, imm, exp});
endfunction

// table columns are kind, funct3, bit 30, operand a, operand b, immediate and expected out
// branch rows expect 1 when taken and 2 when not
task automatic load_table();
    add_row(K_OP,  ADD,  1'b0, 32'hffffffff, 32'h00000002, 20'h0, 32'h00000001);
    add_row(K_OP,  ADD,  1'b1, 32'h00000005, 32'h00000007, 20'h0, 32'hfffffffe);
    add_row(K_OP,  SLT,  1'b0, 32'hffffffff, 32'h00000001, 20'h0, 32'h00000001);
    add_row(K_OP,  SLTU, 1'b0, 32'hffffffff, 32'h00000001, 20'h0, 32'h00000000);
    add_row(K_OP,  SLL,  1'b0, 32'h00000001, 32'h00000023, 20'h0, 32'h00000008);
    add_row(K_OP,  SRL,  1'b0, 32'h80000000, 32'h00000004, 20'h0, 32'h08000000);
    add_row(K_OP,  SRL,  1'b1, 32'h80000000, 32'h00000024, 20'h0, 32'hf8000000);
    add_row(K_OP,  XOR,  1'b0, 32'hf0f0f0f0, 32'h0ff00ff0, 20'h0, 32'hff00ff00);
    add_row(K_OP,  OR,   1'b0, 32'h12340000, 32'h00005678, 20'h0, 32'h12345678);
    add_row(K_OP,  AND,  1'b0, 32'hff00ff00, 32'h0ff00ff0, 20'h0, 32'h0f000f00);
    add_row(K_IMM, ADD,  1'b0, 32'h00000005, 32'h0, 20'h00fff, 32'h00000004);
    add_row(K_IMM, ADD,  1'b0, 32'h00000003, 32'h0, 20'h00800, 32'hfffff803);
    // -2 < 1 holds only as a signed compare
    add_row(K_IMM, SLT,  1'b0, 32'hfffffffe, 32'h0, 20'h00001, 32'h00000001);
    add_row(K_IMM, SLTU, 1'b0, 32'h00000005, 32'h0, 20'h00fff, 32'h00000001);
    // imm bit 10 is instruction bit 30 and makes this srai by 4
    add_row(K_IMM, SRL,  1'b0, 32'h80000010, 32'h0, 20'h00404, 32'hf8000001);
    add_row(K_IMM, XOR,  1'b0, 32'h0000ffff, 32'h0, 20'h00800, 32'hffff07ff);
    add_row(K_IMM, AND,  1'b0, 32'h12345678, 32'h0, 20'h000ff, 32'h00000078);
    add_row(K_LUI, ADD,  1'b0, 32'h0,        32'h0, 20'habcde, 32'habcde000);
    add_row(K_BR,  BEQ,  1'b0, 32'h00000007, 32'h00000007, 20'h0, 32'h00000001);
    add_row(K_BR,  BNE,  1'b0, 32'h00000007, 32'h00000007, 20'h0, 32'h00000002);
    add_row(K_BR,  BLT,  1'b0, 32'hffffffff, 32'h00000001, 20'h0, 32'h00000001);
    add_row(K_BR,  BLTU, 1'b0, 32'hffffffff, 32'h00000001, 20'h0, 32'h00000002);
    add_row(K_BR,  BGE,  1'b0, 32'h00000001, 32'hffffffff, 20'h0, 32'h00000001);
    add_row(K_BR,  BGEU, 1'b0, 32'h00000001, 32'hffffffff, 20'h0, 32'h00000002);
    add_row(K_MEM, ADD,  1'b0, 32'hcafef00d, 32'h0, 20'h00008, 32'hcafef00d);
    add_row(K_X0,  ADD,  1'b0, 32'h00001234, 32'h0, 20'h0, 32'h00000000);
    add_row(K_BAD, ADD,  1'b0, 32'h0,        32'h0, 20'h0, 32'h00000000);
endtask

// instruction formats
function automatic word_t enc_r(input logic [6:0] f7, input reg_sel_t rs2,
                                input reg_sel_t rs1, input logic [2:0] f3,
                                input reg_sel_t rd, input opcode_e op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic word_t enc_i(input logic [11:0] imm, input reg_sel_t rs1,
                                input logic [2:0] f3, input reg_sel_t rd, input opcode_e op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(input logic [11:0] imm, input reg_sel_t rs2,
                                input reg_sel_t rs1);
    // word store, funct3 010
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
endfunction

function automatic word_t enc_b(input logic [12:0] off, input reg_sel_t rs2,
                                input reg_sel_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
endfunction

task automatic emit(input word_t w);
    mem[prog_pc[11:2]] = w;
    prog_pc = prog_pc + 32'd4;
endtask

// lui plus addi with the upper part rounded for the sign-extended low 12 bits
task automatic load_const(input reg_sel_t rd, input word_t val);
    word_t upper;
    upper = (val + 32'h800) >> 12;
    emit({upper[19:0], rd, LUI});
    emit(enc_i(val[11:0], rd, ADD, rd, OPIMM));
endtask

// x1 = a, x2 = b, x3 = result, x4 = data base, x5 = output address
task automatic build_program(input row_t r);
    prog_pc = `CORE_RESET_PC;
    if (r.kind == K_BAD) begin
        // opcode 1111111 is not in the subset
        emit(32'h0000007f);
    end else begin
        load_const(5'd1, r.a);
        load_const(5'd2, r.b);
        load_const(5'd5, `CORE_OUT_ADDR);
        case (r.kind)
            K_OP:  emit(enc_r({1'b0, r.alt, 5'b0}, 5'd2, 5'd1, r.fn, 5'd3, OP));
            K_IMM: emit(enc_i(r.imm[11:0], 5'd1, r.fn, 5'd3, OPIMM));
            K_LUI: emit({r.imm, 5'd3, LUI});
            K_BR: begin
                // taken skips to the addi that writes 1
                emit(enc_b(13'd12, 5'd2, 5'd1, r.fn));
                emit(enc_i(12'd2, 5'd0, ADD, 5'd3, OPIMM));
                emit(enc_b(13'd8, 5'd0, 5'd0, BEQ));
                emit(enc_i(12'd1, 5'd0, ADD, 5'd3, OPIMM));
            end
            K_MEM: begin
                load_const(5'd4, `CORE_DMEM_BASE);
                emit(enc_s(r.imm[11:0], 5'd1, 5'd4));
                emit(enc_i(r.imm[11:0], 5'd4, 3'b010, 5'd3, LOAD));
            end
            // write to x0, which must stay zero
            default: emit(enc_i(12'd0, 5'd1, ADD, 5'd0, OPIMM));
        endcase
        emit(enc_s(12'd0, (r.kind == K_X0) ? 5'd0 : 5'd3, 5'd5));
        emit(enc_s(12'd4, 5'd0, 5'd5));
    end
endtask

`endif

/* test/tb_core.sv */
/*
 * Testbench for core_top.
 * A word memory answers each request after 1 to 3 cycles. Every table
 * row is loaded as a program at the reset pc, run after a clr pulse
 * until halt, and its output store and halt are checked.
 */
`include "core_params.svh"

module tb_core;
    import isa_pkg::*;
    import core_pkg::*;

    // worst program length in instructions, each at most 8 cycles
    localparam int MAX_INSTR = 12;
    localparam int RESET_CYCLES = 4;

    logic  clk;
    logic  rst;
    logic  clr;
    logic  ena;
    addr_t mem_addr;
    word_t mem_wr_data;
    logic  mem_rd_req;
    logic  mem_wr_req;
    word_t mem_rd_data;
    logic  mem_ack;
    word_t out;
    logic  out_valid;
    logic  halt;

    // 4 KiB, program at the reset pc and data at the data base
    word_t mem [0:1023];

    int    word_errs;
    int    halt_errs;
    int    other_errs;
    int    row_idx;
    int    cycles;
    int    limit;
    int    out_cnt;
    word_t out_val;

    // memory model request state
    int    wait_cnt;
    addr_t req_addr;
    logic  req_wr;
    word_t req_data;

    `include "tb_cases.svh"

    core_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .clr         (clr),
        .ena         (ena),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out         (out),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // one outstanding access, ack after a random 1 to 3 cycles
    always @(posedge clk) begin
        mem_ack <= 1'b0;
        if (rst && (mem_rd_req || mem_wr_req)) begin
            if (wait_cnt != 0) begin
                other_errs++;
                $display("new memory request at %0t while one is outstanding", $time);
            end
            req_addr = mem_addr;
            req_wr   = mem_wr_req;
            req_data = mem_wr_data;
            wait_cnt = 1 + int'($urandom % 3);
        end
        if (wait_cnt != 0) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                mem_ack <= 1'b1;
                if (req_wr) begin
                    mem[req_addr[11:2]] = req_data;
                end else begin
                    mem_rd_data <= mem[req_addr[11:2]];
                end
            end
        end
    end

    // output pulses, none may follow a halt
    always @(posedge clk) begin
        if (rst && out_valid) begin
            if (halt) begin
                other_errs++;
                $display("out_valid pulsed after halt at %0t in row %0d", $time, row_idx);
            end
            out_cnt++;
            out_val = out;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles, row %0d never reached halt", cycles, row_idx);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_word(input word_t got, input word_t exp);
        if (got !== exp) begin
            word_errs++;
            $display("FAIL %0t: row %0d out 0x%08h, expected 0x%08h", $time, row_idx, got, exp);
        end
    endtask

    task automatic check_halt(input logic got, input logic exp);
        if (got !== exp) begin
            halt_errs++;
            $display("FAIL %0t: row %0d halt %b, expected %b", $time, row_idx, got, exp);
        end
    endtask

    task automatic run_row(input row_t r);
        // core paused and cleared while the program is written
        @(posedge clk);
        ena <= 1'b0;
        clr <= 1'b1;
        build_program(r);
        @(posedge clk);
        clr <= 1'b0;
        ena <= 1'b1;
        out_cnt = 0;
        @(posedge clk);
        check_halt(halt, 1'b0);
        while (halt !== 1'b1) begin
            @(posedge clk);
        end
        // halt must hold with the core idle
        repeat (4) begin
            @(posedge clk);
            check_halt(halt, 1'b1);
        end
        if (r.kind == K_BAD) begin
            if (out_cnt != 0) begin
                other_errs++;
                $display("row %0d: unknown opcode still produced out_valid", row_idx);
            end
        end else if (out_cnt != 1) begin
            other_errs++;
            $display("row %0d: expected one out_valid pulse, saw %0d", row_idx, out_cnt);
        end else begin
            check_word(out_val, r.exp);
        end
    endtask

    initial begin
        int i;
        rst         = 1'b0;
        clr         = 1'b0;
        ena         = 1'b0;
        mem_rd_data = '0;
        mem_ack     = 1'b0;
        word_errs   = 0;
        halt_errs   = 0;
        other_errs  = 0;
        cycles      = 0;
        wait_cnt    = 0;
        row_idx     = 0;
        void'($urandom(32'hd96c));
        for (i = 0; i < 1024; i++) begin
            mem[i] = (word_t'(i) * 32'h01000193) ^ 32'h5bd1e995;
        end
        load_table();
        limit = rows.size() * (MAX_INSTR * 8 + 8) + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            run_row(rows[row_idx]);
        end
        $display("rows %0d, word errors %0d, halt errors %0d, other errors %0d",
                 rows.size(), word_errs, halt_errs, other_errs);
        if (word_errs == 0 && halt_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* core/core_top.sv */
/*
 * Multi-cycle RV32I integer core.
 * One instruction at a time, fetched and stored over a request/ack
 * memory port. Output and halt stores never reach memory.
 */
module core_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            clr,
    input  logic            ena,

    output core_pkg::addr_t mem_addr,
    output core_pkg::word_t mem_wr_data,
    output logic            mem_rd_req,
    output logic            mem_wr_req,
    input  core_pkg::word_t mem_rd_data,
    input  logic            mem_ack,

    output core_pkg::word_t out,
    output logic            out_valid,
    output logic            halt
);
    import core_pkg::*;

    // decoded operands shared by alu and branch unit
    operand_if ops ();

    reg_sel_t rs1_sel;
    reg_sel_t rs2_sel;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     wr_en;
    reg_sel_t wr_sel;
    word_t    wr_data;

    word_t    alu_result;
    logic     br_taken;
    addr_t    br_target;

    exec_control ctrl0 (
        .clk         (clk),
        .rst         (rst),
        .clr         (clr),
        .ena         (ena),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .out         (out),
        .out_valid   (out_valid),
        .halt        (halt),
        .operands    (ops.src),
        .alu_result  (alu_result),
        .br_taken    (br_taken),
        .br_target   (br_target),
        .rs1_sel     (rs1_sel),
        .rs2_sel     (rs2_sel),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wr_en       (wr_en),
        .wr_sel      (wr_sel),
        .wr_data     (wr_data)
    );

    reg_file rf0 (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_sel   (wr_sel),
        .wr_data  (wr_data)
    );

    alu alu0 (
        .operands (ops.alu_sink),
        .result   (alu_result)
    );

    branch_unit br0 (
        .operands  (ops.br_sink),
        .taken     (br_taken),
        .target_pc (br_target)
    );

endmodule

/* core/exec_control.sv */
/*
 * Fetch/decode/execute controller.
 * Issues one memory request per access and waits for mem_ack, decodes
 * the returned word, feeds the ALU and branch unit, then merges their
 * results into the register write and the next pc.
 */
`include "core_params.svh"

module exec_control (
    input  logic              clk,
    input  logic              rst,
    input  logic              clr,
    input  logic              ena,
    output core_pkg::addr_t   mem_addr,
    output core_pkg::word_t   mem_wr_data,
    output logic              mem_rd_req,
    output logic              mem_wr_req,
    input  core_pkg::word_t   mem_rd_data,
    input  logic              mem_ack,
    output core_pkg::word_t   out,
    output logic              out_valid,
    output logic              halt,
    operand_if.src            operands,
    input  core_pkg::word_t   alu_result,
    input  logic              br_taken,
    input  core_pkg::addr_t   br_target,
    output core_pkg::reg_sel_t rs1_sel,
    output core_pkg::reg_sel_t rs2_sel,
    input  core_pkg::word_t   rs1_data,
    input  core_pkg::word_t   rs2_data,
    output logic              wr_en,
    output core_pkg::reg_sel_t wr_sel,
    output core_pkg::word_t   wr_data
);
    import core_pkg::*;
    import isa_pkg::*;

    ctrl_state_e state, state_nxt;
    addr_t       pc, pc_nxt;
    addr_t       pc_plus4;
    // instruction kept for MEM_WAIT
    word_t       instr_q;
    word_t       cur_instr;
    instr_t      ins;
    word_t       imm;
    addr_t       eff_addr;
    logic        ack_now;

    assign ack_now = ena && mem_ack;

    // decode straight from the bus in the ack cycle, else from the latch
    assign cur_instr = (state == DECODE && mem_ack) ? mem_rd_data : instr_q;
    assign ins       = instr_t'(cur_instr);

    // immediate by format
    always_comb begin
        case (ins.opcode)
            STORE:   imm = {{20{cur_instr[31]}}, cur_instr[31:25], cur_instr[11:7]};
            BRANCH:  imm = {{19{cur_instr[31]}}, cur_instr[31], cur_instr[7],
                            cur_instr[30:25], cur_instr[11:8], 1'b0};
            LUI:     imm = {cur_instr[31:12], 12'b0};
            default: imm = {{20{cur_instr[31]}}, cur_instr[31:20]};
        endcase
    end

    assign rs1_sel  = ins.rs1;
    assign rs2_sel  = ins.rs2;
    assign wr_sel   = ins.rd;
    assign pc_plus4 = pc + addr_t'(4);
    // load and store address
    assign eff_addr = rs1_data + imm;

    assign operands.pc       = pc;
    assign operands.rs1_data = rs1_data;
    assign operands.rs2_data = rs2_data;
    assign operands.imm      = imm;
    assign operands.fn       = ins.funct3;
    assign operands.alt      = cur_instr[30];
    assign operands.use_imm  = (ins.opcode != OP);

    // only output stores use this, out_valid qualifies it
    assign out         = rs2_data;
    assign mem_wr_data = rs2_data;

    always_comb begin
        state_nxt  = state;
        pc_nxt     = pc;
        mem_addr   = pc;
        mem_rd_req = 1'b0;
        mem_wr_req = 1'b0;
        out_valid  = 1'b0;
        wr_en      = 1'b0;
        wr_data    = alu_result;
        case (state)
            FETCH: begin
                mem_rd_req = ena;
                state_nxt  = DECODE;
            end
            DECODE: begin
                if (ack_now) begin
                    state_nxt = FETCH;
                    pc_nxt    = pc_plus4;
                    case (ins.opcode)
                        OP, OPIMM: wr_en = 1'b1;
                        LUI: begin
                            wr_en   = 1'b1;
                            wr_data = imm;
                        end
                        BRANCH: pc_nxt = br_taken ? br_target : pc_plus4;
                        LOAD: begin
                            mem_addr   = eff_addr;
                            mem_rd_req = 1'b1;
                            state_nxt  = MEM_WAIT;
                            pc_nxt     = pc;
                        end
                        STORE: begin
                            if (eff_addr == addr_t'(`CORE_OUT_ADDR)) begin
                                out_valid = 1'b1;
                            end else if (eff_addr == addr_t'(`CORE_HALT_ADDR)) begin
                                state_nxt = HALTED;
                                pc_nxt    = pc;
                            end else begin
                                mem_addr   = eff_addr;
                                mem_wr_req = 1'b1;
                                state_nxt  = MEM_WAIT;
                                pc_nxt     = pc;
                            end
                        end
                        // unknown opcode stops the core
                        default: begin
                            state_nxt = HALTED;
                            pc_nxt    = pc;
                        end
                    endcase
                end
            end
            MEM_WAIT: begin
                if (ack_now) begin
                    // load data lands in rd, a store just completes
                    wr_en     = (ins.opcode == LOAD);
                    wr_data   = mem_rd_data;
                    pc_nxt    = pc_plus4;
                    state_nxt = FETCH;
                end
            end
            default: state_nxt = HALTED;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= FETCH;
            pc      <= addr_t'(`CORE_RESET_PC);
            instr_q <= '0;
            halt    <= 1'b0;
        end else if (clr) begin
            state   <= FETCH;
            pc      <= addr_t'(`CORE_RESET_PC);
            instr_q <= '0;
            halt    <= 1'b0;
        end else if (ena) begin
            state <= state_nxt;
            pc    <= pc_nxt;
            if (state == DECODE && mem_ack) begin
                instr_q <= mem_rd_data;
            end
            // sticky until clr or reset
            if (state_nxt == HALTED) begin
                halt <= 1'b1;
            end
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (!rst)
        !(mem_rd_req && mem_wr_req));

    // the data access is still outstanding here
    a_no_req_in_wait: assert property (@(posedge clk) disable iff (!rst)
        state == MEM_WAIT |-> !mem_rd_req && !mem_wr_req);

    a_halt_state: assert property (@(posedge clk) disable iff (!rst)
        halt |-> state == HALTED);

endmodule

/* rtl/branch_unit.sv */
/*
 * Branch condition and target.
 * BLT and BGE compare signed, BLTU and BGEU unsigned.
 * target_pc is already the fall-through pc when not taken.
 */
module branch_unit (
    operand_if.br_sink      operands,
    output logic            taken,
    output core_pkg::addr_t target_pc
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t a;
    word_t b;

    assign a = operands.rs1_data;
    assign b = operands.rs2_data;

    always_comb begin
        case (branch_fn_e'(operands.fn))
            BEQ:     taken = (a == b);
            BNE:     taken = (a != b);
            BLT:     taken = ($signed(a) < $signed(b));
            BGE:     taken = ($signed(a) >= $signed(b));
            BLTU:    taken = (a < b);
            BGEU:    taken = (a >= b);
            // unused funct3 codes fall through
            default: taken = 1'b0;
        endcase
    end

    // imm is the B-type offset, bit 0 already zero
    assign target_pc = taken ? operands.pc + operands.imm : operands.pc + addr_t'(4);

endmodule

/* rtl/alu.sv */
/*
 * Integer ALU for OP and OPIMM.
 * Operand b is the immediate or rs2; bit 30 turns ADD into SUB for the
 * register form and SRL into SRA for both forms.
 */
module alu (
    operand_if.alu_sink     operands,
    output core_pkg::word_t result
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t      a;
    word_t      b;
    word_t      sra_res;
    logic [4:0] shamt;

    assign a     = operands.rs1_data;
    assign b     = operands.use_imm ? operands.imm : operands.rs2_data;
    // only the low 5 bits shift
    assign shamt = b[4:0];

    // arithmetic shift kept apart so the sign survives
    assign sra_res = $signed(a) >>> shamt;

    always_comb begin
        case (alu_fn_e'(operands.fn))
            ADD:     result = (operands.alt && !operands.use_imm) ? a - b : a + b;
            SLL:     result = a << shamt;
            SLT:     result = word_t'($signed(a) < $signed(b));
            SLTU:    result = word_t'(a < b);
            XOR:     result = a ^ b;
            SRL:     result = operands.alt ? sra_res : a >> shamt;
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

    // funct3 comes from the controller decode
    always_comb begin
        assert (!$isunknown(operands.fn))
        else $error("alu: funct3 unknown");
    end

endmodule

/* rtl/reg_file.sv */
/*
 * General register file, two combinational reads and one write.
 * x0 is not stored: it reads as zero and writes to it are dropped.
 */
`include "core_params.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::reg_sel_t rs1_sel,
    input  core_pkg::reg_sel_t rs2_sel,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data,
    input  logic               wr_en,
    input  core_pkg::reg_sel_t wr_sel,
    input  core_pkg::word_t    wr_data
);
    import core_pkg::*;

    // x1 upward
    word_t regs [1:`CORE_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    // controller must present a clean rd with every write
    a_wr_sel_known: assert property (@(posedge clk) disable iff (!rst)
        wr_en |-> !$isunknown(wr_sel));

endmodule

/* common/operand_if.sv */
/*
 * Decoded operands of the instruction being executed.
 * The controller drives them, the ALU and the branch unit read them
 * in the same cycle.
 */
interface operand_if;
    import core_pkg::*;

    addr_t      pc;
    word_t      rs1_data;
    word_t      rs2_data;
    // sign-extended immediate for the current format
    word_t      imm;
    // funct3
    logic [2:0] fn;
    // instruction bit 30
    logic       alt;
    // operand b from imm instead of rs2
    logic       use_imm;

    modport src (output pc, rs1_data, rs2_data, imm, fn, alt, use_imm);
    modport alu_sink (input rs1_data, rs2_data, imm, fn, alt, use_imm);
    modport br_sink (input pc, rs1_data, rs2_data, imm, fn);

endinterface

/* common/core_pkg.sv */
/*
 * Types internal to the core.
 * Widths follow the define header, so both stay in step.
 */
`include "core_params.svh"

package core_pkg;

    // register and memory data
    typedef logic [`CORE_DATA_W-1:0] word_t;

    // byte address on the memory port and for the pc
    typedef logic [`CORE_ADDR_W-1:0] addr_t;

    // register index
    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_sel_t;

    // controller states
    // FETCH issues the instruction read
    // DECODE waits for it and executes
    // MEM_WAIT waits for a data access
    typedef enum logic [1:0] {
        FETCH    = 2'd0,
        DECODE   = 2'd1,
        MEM_WAIT = 2'd2,
        HALTED   = 2'd3
    } ctrl_state_e;

endpackage

/* common/isa_pkg.sv */
/*
 * RV32I encoding types for the subset the core executes.
 * Shared by the RTL and the testbench program builder.
 */
package isa_pkg;

    // major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OPIMM  = 7'b0010011,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011
    } opcode_e;

    // funct3 for OP and OPIMM
    // bit 30 picks SUB and SRA on top of this
    typedef enum logic [2:0] {
        ADD  = 3'b000,
        SLL  = 3'b001,
        SLT  = 3'b010,
        SLTU = 3'b011,
        XOR  = 3'b100,
        SRL  = 3'b101,
        OR   = 3'b110,
        AND  = 3'b111
    } alu_fn_e;

    // funct3 for BRANCH, 010 and 011 are unused
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_fn_e;

    // register fields of a 32-bit instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } instr_t;

endpackage

/* common/core_params.svh */
/*
 * Core-wide sizes and fixed addresses.
 * Include this header wherever one of the defines is needed.
 * The addresses are byte addresses on the memory port.
 */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and instruction width
`define CORE_DATA_W 32
// byte address width
`define CORE_ADDR_W 32
// general registers, x0 included
`define CORE_NUM_REGS 32

// first fetch after reset or clr
`define CORE_RESET_PC 128

// stores here never reach memory
`define CORE_OUT_ADDR 1000000
`define CORE_HALT_ADDR 1000004

// start of the data area, above the program space
`define CORE_DMEM_BASE 2048

`endif
